/* logic/dcache_pkg.sv */
package dcache_pkg;

    // widths shared by the cache, the miss buffer and the core side
    localparam int xlen = 32;

    localparam int set_count = 8;
    localparam int set_bits = 3;
    localparam int way_count = 4;
    localparam int way_bits = 2;

    localparam int offset_bits = 3;
    localparam int tag_bits = xlen - set_bits - offset_bits;
    localparam int block_bits = 64;

    localparam int miss_entries = 4;
    localparam int miss_ptr_bits = 2;

    // memory tag zero is never handed out
    localparam int mem_tag_bits = 4;

    localparam int prf_bits = 6;
    localparam int rob_bits = 5;

    typedef enum logic [1:0] {
        mem_byte = 2'h0,
        mem_half = 2'h1,
        mem_word = 2'h2
    } mem_size_t;

    typedef enum logic {
        bus_none = 1'b0,
        bus_load = 1'b1
    } bus_command_t;

    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [set_bits-1:0]    set;
        logic [offset_bits-1:0] offset;
    } cache_addr_t;

    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [prf_bits-1:0] prf_idx;
        logic [rob_bits-1:0] rob_idx;
        cache_addr_t         addr;
        mem_size_t           mem_size;
        logic                load_signed;
    } load_request_t;

    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [prf_bits-1:0] prf_idx;
        logic [rob_bits-1:0] rob_idx;
        logic [xlen-1:0]     value;
    } cdb_result_t;

    // block read toward memory with a zero offset
    typedef struct packed {
        bus_command_t    command;
        logic [xlen-1:0] addr;
    } mem_request_t;

    typedef struct packed {
        logic [block_bits-1:0]   data;
        logic [mem_tag_bits-1:0] tag;
    } mem_return_t;

    typedef struct packed {
        logic [set_bits-1:0]   set;
        logic [way_bits-1:0]   way;
        logic [tag_bits-1:0]   tag;
        logic [block_bits-1:0] data;
    } fill_t;

    typedef struct packed {
        load_request_t         req;
        logic [block_bits-1:0] block;
    } miss_head_t;

endpackage

/* logic/tree_plru.sv */
`timescale 1ns/1ps

module tree_plru (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic [dcache_pkg::set_bits-1:0] lookup_set,
    input  logic                          touch_valid,
    input  logic [dcache_pkg::set_bits-1:0] touch_set,
    input  logic [dcache_pkg::way_bits-1:0] touch_way,
    output logic [dcache_pkg::way_bits-1:0] victim_way
);
    import dcache_pkg::*;

    // in each set bit 0 picks the half, bit 1 the left pair and bit 2 the right pair
    //
    //          [0]
    //         /   \
    //       [1]   [2]
    //      /  \   /  \
    //     0   1  2    3
    logic [set_count-1:0][2:0] tree_q;
    logic [2:0]                lookup_bits;

    assign lookup_bits = tree_q[lookup_set];

    // follow the bits down to the least recently used leaf
    always_comb begin
        if (lookup_bits[0]) begin
            victim_way = {1'b1, lookup_bits[2]};
        end else begin
            victim_way = {1'b0, lookup_bits[1]};
        end
    end

    // point every node on the touched path at the other side
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tree_q <= '0;
        end else if (touch_valid) begin
            tree_q[touch_set][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree_q[touch_set][2] <= ~touch_way[0];
            end else begin
                tree_q[touch_set][1] <= ~touch_way[0];
            end
        end
    end

    // hit way and fill way both arrive from other blocks
    assert property (@(posedge clock) disable iff (!arst_n)
        touch_valid |-> !$isunknown(touch_way))
    else $error("tree_plru: touch with unknown way");

endmodule

/* logic/tag_data_array.sv */
`timescale 1ns/1ps

module tag_data_array (
    input  logic                              clock,
    input  logic                              arst_n,
    input  dcache_pkg::cache_addr_t           lookup_addr,
    input  logic                              lookup_valid,
    output logic                              hit,
    output logic [dcache_pkg::way_bits-1:0]   hit_way,
    output logic [dcache_pkg::block_bits-1:0] hit_block,
    input  logic                              fill_valid,
    input  dcache_pkg::fill_t                 fill
);
    import dcache_pkg::*;

    logic [set_count-1:0][way_count-1:0] valid_q;
    logic [tag_bits-1:0]                 tag_mem [set_count][way_count];
    logic [block_bits-1:0]               data_mem [set_count][way_count];

    logic [way_count-1:0] match;
    logic [way_count-1:0] fill_match;
    logic [way_bits-1:0]  fill_way;

    // compare every way of the addressed set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < way_count; w++) begin
            match[w] = valid_q[lookup_addr.set][w]
                && (tag_mem[lookup_addr.set][w] == lookup_addr.tag);
            if (match[w]) begin
                hit_way = way_bits'(w);
            end
        end
    end

    assign hit = lookup_valid && (|match);
    assign hit_block = data_mem[lookup_addr.set][hit_way];

    // two misses to one block both fill into a single way
    always_comb begin
        fill_way = fill.way;
        for (int w = 0; w < way_count; w++) begin
            fill_match[w] = valid_q[fill.set][w] && (tag_mem[fill.set][w] == fill.tag);
            if (fill_match[w]) begin
                fill_way = way_bits'(w);
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (fill_valid) begin
            valid_q[fill.set][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid) begin
            tag_mem[fill.set][fill_way] <= fill.tag;
            data_mem[fill.set][fill_way] <= fill.data;
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        lookup_valid |-> $onehot0(match))
    else $error("tag_data_array: block present in more than one way");

endmodule

/* logic/load_miss_buffer.sv */
`timescale 1ns/1ps

module load_miss_buffer (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic                                flush,
    input  logic                                alloc_valid,
    input  dcache_pkg::load_request_t           alloc_req,
    input  logic [dcache_pkg::way_bits-1:0]     alloc_way,
    input  logic                                hit_busy,
    output dcache_pkg::mem_request_t            mem_req,
    input  logic                                mem_ack_valid,
    input  logic [dcache_pkg::mem_tag_bits-1:0] mem_ack_tag,
    input  dcache_pkg::mem_return_t             mem_return,
    output logic                                head_ready,
    output dcache_pkg::miss_head_t              head,
    output logic                                fill_valid,
    output dcache_pkg::fill_t                   fill,
    output logic                                full
);
    import dcache_pkg::*;

    typedef struct packed {
        load_request_t           req;
        logic [way_bits-1:0]     way;
        logic [mem_tag_bits-1:0] mem_tag;
        logic [block_bits-1:0]   block;
    } entry_t;

    entry_t                   entry_q [miss_entries];
    logic [miss_entries-1:0]  valid_q;
    logic [miss_entries-1:0]  sent_q;
    logic [miss_entries-1:0]  done_q;
    logic [miss_ptr_bits-1:0] head_ptr;
    logic [miss_ptr_bits-1:0] send_ptr;
    logic [miss_ptr_bits-1:0] tail_ptr;

    logic                    send_pending;
    logic                    ack_take;
    logic                    retire;
    logic [miss_entries-1:0] ret_match;
    entry_t                  send_entry;
    entry_t                  head_entry;

    // entries run from head up to tail, so a valid tail slot means full
    assign full = valid_q[tail_ptr];

    assign send_entry = entry_q[send_ptr];
    assign send_pending = valid_q[send_ptr] && !sent_q[send_ptr];
    assign ack_take = send_pending && mem_ack_valid && (mem_ack_tag != '0);

    always_comb begin
        mem_req.command = send_pending ? bus_load : bus_none;
        if (send_pending) begin
            mem_req.addr = {send_entry.req.addr.tag, send_entry.req.addr.set,
                            {offset_bits{1'b0}}};
        end else begin
            mem_req.addr = '0;
        end
    end

    // a returned block completes every entry waiting on its tag
    always_comb begin
        for (int i = 0; i < miss_entries; i++) begin
            ret_match[i] = valid_q[i] && sent_q[i] && !done_q[i]
                && (mem_return.tag != '0) && (entry_q[i].mem_tag == mem_return.tag);
        end
    end

    assign head_entry = entry_q[head_ptr];
    assign head_ready = valid_q[head_ptr] && done_q[head_ptr];
    // the result bus belongs to a hit first
    assign retire = head_ready && !hit_busy;

    assign head.req = head_entry.req;
    assign head.block = head_entry.block;

    assign fill_valid = retire;
    assign fill.set = head_entry.req.addr.set;
    assign fill.way = head_entry.way;
    assign fill.tag = head_entry.req.addr.tag;
    assign fill.data = head_entry.block;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            sent_q <= '0;
            done_q <= '0;
            head_ptr <= '0;
            send_ptr <= '0;
            tail_ptr <= '0;
        end else if (flush) begin
            valid_q <= '0;
            sent_q <= '0;
            done_q <= '0;
            head_ptr <= '0;
            send_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            done_q <= done_q | ret_match;
            if (alloc_valid) begin
                valid_q[tail_ptr] <= 1'b1;
                sent_q[tail_ptr] <= 1'b0;
                done_q[tail_ptr] <= 1'b0;
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (ack_take) begin
                sent_q[send_ptr] <= 1'b1;
                send_ptr <= send_ptr + 1'b1;
            end
            if (retire) begin
                valid_q[head_ptr] <= 1'b0;
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            entry_q[tail_ptr].req <= alloc_req;
            entry_q[tail_ptr].way <= alloc_way;
        end
        if (ack_take) begin
            entry_q[send_ptr].mem_tag <= mem_ack_tag;
        end
        for (int i = 0; i < miss_entries; i++) begin
            if (ret_match[i]) begin
                entry_q[i].block <= mem_return.data;
            end
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        alloc_valid |-> !full)
    else $error("load_miss_buffer: allocation while full");

    // between send and tail sit only allocated, unsent entries
    assert property (@(posedge clock) disable iff (!arst_n)
        (send_ptr != tail_ptr) |-> (valid_q[send_ptr] && !sent_q[send_ptr]))
    else $error("load_miss_buffer: send pointer ahead of tail");

endmodule

/* logic/load_writeback.sv */
`timescale 1ns/1ps

module load_writeback (
    input  logic                              hit,
    input  dcache_pkg::load_request_t         hit_req,
    input  logic [dcache_pkg::block_bits-1:0] hit_block,
    input  logic                              head_ready,
    input  dcache_pkg::miss_head_t            head,
    output logic                              cdb_valid,
    output dcache_pkg::cdb_result_t           cdb
);
    import dcache_pkg::*;

    // pick the word, then the byte or half, then extend
    function automatic logic [xlen-1:0] format_value(load_request_t req,
                                                     logic [block_bits-1:0] block);
        logic [31:0] word;
        logic [7:0]  byte_val;
        logic [15:0] half_val;
        word = req.addr.offset[2] ? block[63:32] : block[31:0];
        byte_val = word[8*req.addr.offset[1:0] +: 8];
        half_val = word[16*req.addr.offset[1] +: 16];
        case (req.mem_size)
            mem_byte: begin
                format_value = req.load_signed ? {{(xlen-8){byte_val[7]}}, byte_val}
                                               : {{(xlen-8){1'b0}}, byte_val};
            end
            mem_half: begin
                format_value = req.load_signed ? {{(xlen-16){half_val[15]}}, half_val}
                                               : {{(xlen-16){1'b0}}, half_val};
            end
            default: format_value = word;
        endcase
    endfunction

    always_comb begin
        cdb = '0;
        cdb_valid = hit || head_ready;
        if (hit) begin
            cdb.pc = hit_req.pc;
            cdb.prf_idx = hit_req.prf_idx;
            cdb.rob_idx = hit_req.rob_idx;
            cdb.value = format_value(hit_req, hit_block);
        end else if (head_ready) begin
            cdb.pc = head.req.pc;
            cdb.prf_idx = head.req.prf_idx;
            cdb.rob_idx = head.req.rob_idx;
            cdb.value = format_value(head.req, head.block);
        end
    end

endmodule

/* logic/dcache.sv */
`timescale 1ns/1ps

module dcache (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic                                load_valid,
    input  dcache_pkg::load_request_t           load_req,
    input  logic                                mem_ack_valid,
    input  logic [dcache_pkg::mem_tag_bits-1:0] mem_ack_tag,
    input  dcache_pkg::mem_return_t             mem_return,
    input  logic                                commit_mis_pred,
    output logic                                cdb_valid,
    output dcache_pkg::cdb_result_t             cdb,
    output dcache_pkg::mem_request_t            mem_req,
    output logic                                miss_buffer_full
);
    import dcache_pkg::*;

    logic                  hit;
    logic [way_bits-1:0]   hit_way;
    logic [block_bits-1:0] hit_block;
    logic [way_bits-1:0]   victim_way;
    logic                  alloc_valid;
    logic                  head_ready;
    miss_head_t            head;
    logic                  fill_valid;
    fill_t                 fill;

    logic                  touch_valid;
    logic [set_bits-1:0]   touch_set;
    logic [way_bits-1:0]   touch_way;

    assign alloc_valid = load_valid && !hit;

    // a fill only retires when no hit is present, so one touch port is enough
    assign touch_valid = hit || fill_valid;
    assign touch_set = hit ? load_req.addr.set : fill.set;
    assign touch_way = hit ? hit_way : fill.way;

    tree_plru tree_plru_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .lookup_set  (load_req.addr.set),
        .touch_valid (touch_valid),
        .touch_set   (touch_set),
        .touch_way   (touch_way),
        .victim_way  (victim_way)
    );

    tag_data_array tag_data_array_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .lookup_addr  (load_req.addr),
        .lookup_valid (load_valid),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_block    (hit_block),
        .fill_valid   (fill_valid),
        .fill         (fill)
    );

    load_miss_buffer load_miss_buffer_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .flush         (commit_mis_pred),
        .alloc_valid   (alloc_valid),
        .alloc_req     (load_req),
        .alloc_way     (victim_way),
        .hit_busy      (hit),
        .mem_req       (mem_req),
        .mem_ack_valid (mem_ack_valid),
        .mem_ack_tag   (mem_ack_tag),
        .mem_return    (mem_return),
        .head_ready    (head_ready),
        .head          (head),
        .fill_valid    (fill_valid),
        .fill          (fill),
        .full          (miss_buffer_full)
    );

    load_writeback load_writeback_inst (
        .hit        (hit),
        .hit_req    (load_req),
        .hit_block  (hit_block),
        .head_ready (head_ready),
        .head       (head),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb)
    );

endmodule

/* tests/dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      load_valid,
    input  dcache_pkg::load_request_t load_req,
    input  logic                      cdb_valid,
    input  dcache_pkg::cdb_result_t   cdb,
    input  logic                      miss_buffer_full,
    input  logic                      end_check,
    output int                        value_errors,
    output int                        other_errors
);
    import dcache_pkg::*;

    // expected kind per rob index is 0 miss, 1 hit or 2 flushed
    logic [xlen-1:0] exp_value [32];
    int              exp_kind [32];
    logic            listed [32];
    logic            seen [32];
    logic            file_bad = 1'b0;
    logic            full_seen = 1'b0;
    int              last_miss_rob = 0;
    int              value_count = 0;
    int              other_count = 0;

    assign value_errors = value_count;
    assign other_errors = other_count;

    initial begin
        int              fd;
        int              code;
        int              rob;
        int              size;
        int              sgn;
        int              kind_flag;
        string           line;
        byte             kind;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] value;
        for (int i = 0; i < 32; i++) begin
            listed[i] = 1'b0;
            seen[i] = 1'b0;
        end
        fd = $fopen("tests/dcache_cases.txt", "r");
        if (fd == 0) begin
            file_bad = 1'b1;
        end
        while (fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] == "L") begin
                code = $sscanf(line, "%c %d %h %d %d %h %d", kind, rob, addr, size, sgn,
                               value, kind_flag);
                exp_value[rob] = value;
                exp_kind[rob] = kind_flag;
                listed[rob] = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    end

    always @(posedge clock) begin
        int   rob;
        logic same_cycle;
        if (arst_n && miss_buffer_full) begin
            full_seen = 1'b1;
        end
        if (arst_n && cdb_valid) begin
            rob = cdb.rob_idx;
            // a hit answers in the cycle of its own request
            same_cycle = load_valid && (load_req.rob_idx == cdb.rob_idx);
            if (!listed[rob] || exp_kind[rob] == 2) begin
                $display("%0t: result for rob %0d, which should produce none", $time, rob);
                other_count++;
            end else if (seen[rob]) begin
                $display("%0t: second result for rob %0d", $time, rob);
                other_count++;
            end else begin
                seen[rob] = 1'b1;
                if (same_cycle != (exp_kind[rob] == 1)) begin
                    $display("%0t: rob %0d result same-cycle is %0d, expected the other way",
                             $time, rob, same_cycle);
                    other_count++;
                end
                // misses leave the buffer in the order they were issued
                if (!same_cycle) begin
                    if (rob <= last_miss_rob) begin
                        $display("%0t: miss result for rob %0d came out of allocation order",
                                 $time, rob);
                        other_count++;
                    end
                    last_miss_rob = rob;
                end
                if (cdb.value !== exp_value[rob]) begin
                    $display("** Error at %0t: cdb.value rob %0d expected %h actual %h",
                             $time, rob, exp_value[rob], cdb.value);
                    value_count++;
                end
                if (cdb.pc !== 32'h1000 + rob * 4) begin
                    $display("** Error at %0t: cdb.pc rob %0d expected %h actual %h",
                             $time, rob, 32'h1000 + rob * 4, cdb.pc);
                    value_count++;
                end
                if (cdb.prf_idx !== prf_bits'(rob)) begin
                    $display("** Error at %0t: cdb.prf_idx rob %0d expected %h actual %h",
                             $time, rob, prf_bits'(rob), cdb.prf_idx);
                    value_count++;
                end
            end
        end
        if (end_check) begin
            if (file_bad) begin
                $display("checker could not open tests/dcache_cases.txt");
                other_count++;
            end
            if (!full_seen) begin
                $display("miss_buffer_full never rose");
                other_count++;
            end
            for (int i = 0; i < 32; i++) begin
                if (listed[i] && exp_kind[i] != 2 && !seen[i]) begin
                    $display("no result ever came for rob %0d", i);
                    other_count++;
                end
            end
        end
    end

endmodule

/* tests/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    logic                    clock;
    logic                    arst_n;
    logic                    load_valid;
    load_request_t           load_req;
    logic                    mem_ack_valid = 1'b0;
    logic [mem_tag_bits-1:0] mem_ack_tag = '0;
    mem_return_t             mem_return = '0;
    logic                    commit_mis_pred;
    logic                    cdb_valid;
    cdb_result_t             cdb;
    mem_request_t            mem_req;
    logic                    miss_buffer_full;
    logic                    end_check;
    int                      value_errors;
    int                      other_errors;
    int                      setup_errors = 0;

    byte                     kind_q [$];
    int                      rob_q [$];
    logic [xlen-1:0]         addr_q [$];
    int                      size_q [$];
    int                      sgn_q [$];

    // outstanding block reads in the memory model
    int                      ret_wait [$];
    logic [mem_tag_bits-1:0] ret_tag [$];
    logic [block_bits-1:0]   ret_data [$];
    logic [mem_tag_bits-1:0] next_tag = 4'd1;

    dcache dcache_inst (
        .clock            (clock),
        .arst_n           (arst_n),
        .load_valid       (load_valid),
        .load_req         (load_req),
        .mem_ack_valid    (mem_ack_valid),
        .mem_ack_tag      (mem_ack_tag),
        .mem_return       (mem_return),
        .commit_mis_pred  (commit_mis_pred),
        .cdb_valid        (cdb_valid),
        .cdb              (cdb),
        .mem_req          (mem_req),
        .miss_buffer_full (miss_buffer_full)
    );

    dcache_checker checker_inst (
        .clock            (clock),
        .arst_n           (arst_n),
        .load_valid       (load_valid),
        .load_req         (load_req),
        .cdb_valid        (cdb_valid),
        .cdb              (cdb),
        .miss_buffer_full (miss_buffer_full),
        .end_check        (end_check),
        .value_errors     (value_errors),
        .other_errors     (other_errors)
    );

    // byte at a is the low byte of a*7+3
    function automatic logic [block_bits-1:0] block_data(logic [xlen-1:0] base);
        logic [xlen-1:0] product;
        block_data = '0;
        for (int i = 0; i < 8; i++) begin
            product = (base + i) * 7 + 3;
            block_data[8*i +: 8] = product[7:0];
        end
    endfunction

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // acks a request at once, returns its block three cycles later
    always @(negedge clock) begin
        mem_ack_valid = 1'b0;
        mem_ack_tag = '0;
        mem_return = '0;
        for (int i = 0; i < ret_wait.size(); i++) begin
            ret_wait[i] = ret_wait[i] - 1;
        end
        if (ret_wait.size() != 0 && ret_wait[0] == 0) begin
            mem_return.tag = ret_tag.pop_front();
            mem_return.data = ret_data.pop_front();
            void'(ret_wait.pop_front());
        end
        if (arst_n && mem_req.command == bus_load) begin
            mem_ack_valid = 1'b1;
            mem_ack_tag = next_tag;
            ret_wait.push_back(3);
            ret_tag.push_back(next_tag);
            ret_data.push_back(block_data(mem_req.addr));
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
    end

    task automatic drive_load(int rob, logic [xlen-1:0] addr, int size, int sgn);
        while (miss_buffer_full) begin
            @(negedge clock);
        end
        load_valid = 1'b1;
        load_req.pc = 32'h1000 + rob * 4;
        load_req.prf_idx = prf_bits'(rob);
        load_req.rob_idx = rob_bits'(rob);
        load_req.addr = addr;
        load_req.mem_size = mem_size_t'(size);
        load_req.load_signed = sgn[0];
        @(negedge clock);
        load_valid = 1'b0;
    endtask

    task automatic pulse_flush();
        commit_mis_pred = 1'b1;
        @(negedge clock);
        commit_mis_pred = 1'b0;
    endtask

    // idle until no request or return is left, then let the head retire
    task automatic drain_memory();
        logic busy;
        do begin
            @(negedge clock);
            busy = (mem_req.command == bus_load);
            @(posedge clock);
            busy = busy || (ret_wait.size() != 0);
        end while (busy);
        repeat (4) @(negedge clock);
    endtask

    initial begin
        int              fd;
        int              code;
        int              rob;
        int              size;
        int              sgn;
        longint          limit;
        string           line;
        byte             kind;
        logic [xlen-1:0] addr;
        arst_n = 1'b0;
        load_valid = 1'b0;
        load_req = '0;
        commit_mis_pred = 1'b0;
        end_check = 1'b0;
        fd = $fopen("tests/dcache_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/dcache_cases.txt");
            setup_errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%c %d %h %d %d", kind, rob, addr, size, sgn);
                kind_q.push_back(kind);
                rob_q.push_back(rob);
                addr_q.push_back(addr);
                size_q.push_back(size);
                sgn_q.push_back(sgn);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        limit = (kind_q.size() * 40 + 10) * 20;
        fork
            begin
                #(limit);
                $display("timeout after %0d ns, the cases did not finish", limit);
                $display("Simulation FAILED");
                $finish;
            end
        join_none
        repeat (10) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        foreach (kind_q[i]) begin
            if (kind_q[i] == "L") begin
                drive_load(rob_q[i], addr_q[i], size_q[i], sgn_q[i]);
            end else if (kind_q[i] == "F") begin
                pulse_flush();
            end else begin
                drain_memory();
            end
        end
        drain_memory();
        end_check = 1'b1;
        @(negedge clock);
        end_check = 1'b0;
        $display("errors: %0d value, %0d other, %0d setup", value_errors, other_errors,
                 setup_errors);
        if (value_errors + other_errors + setup_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* dcache_project.f */
logic/dcache_pkg.sv
logic/tree_plru.sv
logic/tag_data_array.sv
logic/load_miss_buffer.sv
logic/load_writeback.sv
logic/dcache.sv
tests/dcache_checker.sv
tests/tb_dcache.sv

/* tests/dcache_cases.txt */
# kind rob addr size(0 byte 1 half 2 word) signed expected hit(0 miss 1 hit 2 none)
# kind L is a load, F a flush, W waits for memory to drain
L 1 00000120 2 0 f8f1eae3 0
W
L 2 00000121 0 1 ffffffea 1
L 3 00000121 0 0 000000ea 1
L 4 00000122 1 1 fffff8f1 1
L 5 00000124 2 0 140d06ff 1
L 6 00000126 1 0 0000140d 1
L 7 00000125 0 1 00000006 1
L 8 00000200 2 0 18110a03 0
L 9 00000208 2 0 5049423b 0
L 10 00000212 0 1 ffffff81 0
L 11 00000218 2 0 c0b9b2ab 0
L 12 00000228 2 0 3029221b 0
W
L 13 00000430 2 0 68615a53 0
W
L 14 00000470 2 0 28211a13 0
W
L 15 000004b0 2 0 e8e1dad3 0
W
L 16 000004f0 2 0 a8a19a93 0
W
L 17 00000534 2 0 847d766f 0
W
L 18 00000430 2 0 68615a53 0
W
L 19 000004f0 2 0 a8a19a93 1
L 20 00000530 2 0 68615a53 1
L 21 0000003a 1 1 ffffa099 0
L 22 00000120 2 0 f8f1eae3 1
L 23 00000124 0 0 000000ff 1
L 24 00000124 0 1 ffffffff 1
L 25 00000120 1 0 0000eae3 1
L 26 00000124 2 0 140d06ff 1
L 27 00000127 0 0 00000014 1
W
L 28 00000648 2 0 00000000 2
L 29 00000690 2 0 00000000 2
F
W
L 30 00000648 2 0 100902fb 0
W
L 31 00000648 0 1 fffffffb 1
W
